//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_join
FLIST     ?= axi_join.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- axi_join.f
verilog/axi_pkg.sv
verilog/join_pkg.sv
verilog/register_slice.sv
verilog/axi_pipe.sv
verilog/axi_arbiter.sv
verilog/axi_join.sv
sim/axi_slave_model.sv
sim/tb_axi_join.sv

//--- sim/axi_slave_model.sv
module axi_slave_model #(
   parameter int SEED = 0
) (
   input  logic           clk,
   input  logic           rstn,
   input  axi_pkg::id_t   m_awid,
   input  axi_pkg::addr_t m_awaddr,
   input  axi_pkg::len_t  m_awlen,
   input  axi_pkg::size_t m_awsize,
   input  logic           m_awvalid,
   output logic           m_awready,
   input  axi_pkg::data_t m_wdata,
   input  axi_pkg::strb_t m_wstrb,
   input  logic           m_wlast,
   input  logic           m_wvalid,
   output logic           m_wready,
   input  axi_pkg::id_t   m_arid,
   input  axi_pkg::addr_t m_araddr,
   input  axi_pkg::len_t  m_arlen,
   input  axi_pkg::size_t m_arsize,
   input  logic           m_arvalid,
   output logic           m_arready,
   output axi_pkg::id_t   m_rid,
   output axi_pkg::data_t m_rdata,
   output logic           m_rlast,
   output axi_pkg::resp_t m_rresp,
   output logic           m_rvalid,
   input  logic           m_rready,
   output axi_pkg::id_t   m_bid,
   output axi_pkg::resp_t m_bresp,
   output logic           m_bvalid,
   input  logic           m_bready
);

   int             seed;
   int             w_beats;    // data beats taken but not yet answered
   axi_pkg::id_t   b_q[$];
   axi_pkg::id_t   ar_id_q[$];
   axi_pkg::addr_t ar_addr_q[$];
   axi_pkg::addr_t rd_addr;
   logic           r_done, b_done;

   initial begin
      seed = SEED;
      {m_awready, m_wready, m_arready, m_rvalid, m_bvalid} = '0;
      {m_rid, m_rdata, m_rlast, m_rresp, m_bid, m_bresp} = '0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         b_q.delete();
         ar_id_q.delete();
         ar_addr_q.delete();
         w_beats = 0;
         #2;
         {m_awready, m_wready, m_arready, m_rvalid, m_bvalid} = '0;
      end else begin
         if (m_awvalid && m_awready) b_q.push_back(m_awid);
         if (m_wvalid && m_wready) w_beats++;
         if (m_arvalid && m_arready) begin
            ar_id_q.push_back(m_arid);
            ar_addr_q.push_back(m_araddr);
         end
         r_done = m_rvalid && m_rready;
         b_done = m_bvalid && m_bready;
         #2;
         if (r_done) m_rvalid = 1'b0;
         if (b_done) m_bvalid = 1'b0;
         if (!m_rvalid && ar_id_q.size() > 0) begin
            rd_addr = ar_addr_q.pop_front();
            m_rid = ar_id_q.pop_front();
            m_rdata = {rd_addr, rd_addr};  // read data is the address twice
            m_rlast = 1'b1;
            m_rresp = 2'b00;
            m_rvalid = 1'b1;
         end
         if (!m_bvalid && b_q.size() > 0 && w_beats > 0) begin
            m_bid = b_q.pop_front();
            m_bresp = 2'b00;
            m_bvalid = 1'b1;
            w_beats--;
         end
         m_awready = ($random(seed) & 3) != 0;  // ready about three cycles in four
         m_wready = ($random(seed) & 3) != 0;
         m_arready = ($random(seed) & 3) != 0;
      end
   end

endmodule

//--- sim/tb_axi_join.sv
module tb_axi_join;

   localparam int SEED = 32'h3470_50ff;
   localparam int N_OPS = 12;                        // writes and reads per master
   localparam int LIMIT = 4 * N_OPS * 40 + 16 + 8;   // cycles for all transactions plus reset

   logic clk, rstn, idle;
   int   seed, errors, tests, cycles;
   int   iss_aw, iss_w, iss_ar, fwd_aw, fwd_w, fwd_ar, wr_done, rd_done;

   logic [1:0] awvalid, awready, wvalid, wready, arvalid, arready;
   logic [1:0] rvalid, rready, bvalid, bready, wlast, rlast;
   axi_pkg::id_t   [1:0] awid, arid, rid, bid;
   axi_pkg::addr_t [1:0] awaddr, araddr;
   axi_pkg::len_t  [1:0] awlen, arlen;
   axi_pkg::size_t [1:0] awsize, arsize;
   axi_pkg::data_t [1:0] wdata, rdata;
   axi_pkg::strb_t [1:0] wstrb;
   axi_pkg::resp_t [1:0] rresp, bresp;

   axi_pkg::id_t   m_awid, m_arid, m_rid, m_bid;
   axi_pkg::addr_t m_awaddr, m_araddr;
   axi_pkg::len_t  m_awlen, m_arlen;
   axi_pkg::size_t m_awsize, m_arsize;
   axi_pkg::data_t m_wdata, m_rdata;
   axi_pkg::strb_t m_wstrb;
   axi_pkg::resp_t m_rresp, m_bresp;
   logic m_awvalid, m_awready, m_wvalid, m_wready, m_wlast, m_arvalid, m_arready;
   logic m_rvalid, m_rready, m_rlast, m_bvalid, m_bready;

   logic [axi_pkg::AW_WIDTH-1:0] aw_q[2][$];  // one queue per master in the order it issued
   logic [axi_pkg::AR_WIDTH-1:0] ar_q[2][$];
   logic [71:0]                  w_q[2][$];
   int                           owner_q[$];
   axi_pkg::addr_t               rd_exp[16][$];
   int                           wr_pending[16];

   axi_join axi_join_inst (
      .a_awid(awid[0]), .a_awaddr(awaddr[0]), .a_awlen(awlen[0]), .a_awsize(awsize[0]),
      .a_awvalid(awvalid[0]), .a_awready(awready[0]), .a_wdata(wdata[0]), .a_wstrb(wstrb[0]),
      .a_wlast(wlast[0]), .a_wvalid(wvalid[0]), .a_wready(wready[0]), .a_arid(arid[0]),
      .a_araddr(araddr[0]), .a_arlen(arlen[0]), .a_arsize(arsize[0]),
      .a_arvalid(arvalid[0]), .a_arready(arready[0]), .a_rid(rid[0]), .a_rdata(rdata[0]),
      .a_rlast(rlast[0]), .a_rresp(rresp[0]), .a_rvalid(rvalid[0]), .a_rready(rready[0]),
      .a_bid(bid[0]), .a_bresp(bresp[0]), .a_bvalid(bvalid[0]), .a_bready(bready[0]),
      .b_awid(awid[1]), .b_awaddr(awaddr[1]), .b_awlen(awlen[1]), .b_awsize(awsize[1]),
      .b_awvalid(awvalid[1]), .b_awready(awready[1]), .b_wdata(wdata[1]), .b_wstrb(wstrb[1]),
      .b_wlast(wlast[1]), .b_wvalid(wvalid[1]), .b_wready(wready[1]), .b_arid(arid[1]),
      .b_araddr(araddr[1]), .b_arlen(arlen[1]), .b_arsize(arsize[1]),
      .b_arvalid(arvalid[1]), .b_arready(arready[1]), .b_rid(rid[1]), .b_rdata(rdata[1]),
      .b_rlast(rlast[1]), .b_rresp(rresp[1]), .b_rvalid(rvalid[1]), .b_rready(rready[1]),
      .b_bid(bid[1]), .b_bresp(bresp[1]), .b_bvalid(bvalid[1]), .b_bready(bready[1]),
      .*
   );

   axi_slave_model #(.SEED(SEED)) slave_model_inst (.*);

   always #10 clk = ~clk;

   task automatic note_mismatch(input string msg);
      errors++;
      $display("mismatch at %0t: %s", $time, msg);
   endtask

   // response valids must follow the id bit of their master
   assert property (@(posedge clk) disable iff (!rstn) rvalid[0] |-> !rid[0][join_pkg::ID_BIT])
      else note_mismatch("a_rvalid raised for a master B id");
   assert property (@(posedge clk) disable iff (!rstn) rvalid[1] |-> rid[1][join_pkg::ID_BIT])
      else note_mismatch("b_rvalid raised for a master A id");
   assert property (@(posedge clk) disable iff (!rstn) bvalid[0] |-> !bid[0][join_pkg::ID_BIT])
      else note_mismatch("a_bvalid raised for a master B id");
   assert property (@(posedge clk) disable iff (!rstn) bvalid[1] |-> bid[1][join_pkg::ID_BIT])
      else note_mismatch("b_bvalid raised for a master A id");
   assert property (@(posedge clk) disable iff (!rstn)
      idle |-> !(m_awvalid || m_wvalid || m_arvalid || rvalid != 0 || bvalid != 0))
      else note_mismatch("valid raised while no stimulus was applied");

   always @(posedge clk) begin
      int p;
      if (rstn) begin
         if (m_awvalid && m_awready) begin
            p = m_awid[join_pkg::ID_BIT];
            assert (aw_q[p].size() > 0 && aw_q[p][0] == {m_awid, m_awaddr, m_awlen, m_awsize})
               else note_mismatch($sformatf("m_aw id %0d changed or out of order", m_awid));
            if (aw_q[p].size() > 0) aw_q[p].delete(0);
            fwd_aw++;
         end
         if (m_wvalid && m_wready) begin
            p = owner_q.size() > 0 ? owner_q.pop_front() : 0;
            assert (w_q[p].size() > 0 && w_q[p][0] == {m_wdata, m_wstrb} && m_wlast)
               else note_mismatch($sformatf("m_w beat does not belong to master %0d", p));
            if (w_q[p].size() > 0) w_q[p].delete(0);
            fwd_w++;
         end
         if (m_arvalid && m_arready) begin
            p = m_arid[join_pkg::ID_BIT];
            assert (ar_q[p].size() > 0 && ar_q[p][0] == {m_arid, m_araddr, m_arlen, m_arsize})
               else note_mismatch($sformatf("m_ar id %0d changed or out of order", m_arid));
            if (ar_q[p].size() > 0) ar_q[p].delete(0);
            fwd_ar++;
         end
         for (int i = 0; i < 2; i++) begin
            if (awvalid[i] && awready[i]) begin
               aw_q[i].push_back({awid[i], awaddr[i], awlen[i], awsize[i]});
               owner_q.push_back(i);  // w beats leave in the order their aw was taken
               wr_pending[awid[i]]++;
               iss_aw++;
            end
            if (wvalid[i] && wready[i]) begin
               w_q[i].push_back({wdata[i], wstrb[i]});
               iss_w++;
            end
            if (arvalid[i] && arready[i]) begin
               ar_q[i].push_back({arid[i], araddr[i], arlen[i], arsize[i]});
               rd_exp[arid[i]].push_back(araddr[i]);
               iss_ar++;
            end
            if (rvalid[i] && rready[i]) begin
               assert (rid[i][join_pkg::ID_BIT] == i && rd_exp[rid[i]].size() > 0 &&
                       rdata[i] == {rd_exp[rid[i]][0], rd_exp[rid[i]][0]} && rlast[i] &&
                       rresp[i] == 2'b00)
                  else note_mismatch($sformatf("read data for id %0d is wrong", rid[i]));
               if (rd_exp[rid[i]].size() > 0) rd_exp[rid[i]].delete(0);
               rd_done++;
            end
            if (bvalid[i] && bready[i]) begin
               assert (wr_pending[bid[i]] > 0 && bresp[i] == 2'b00)
                  else note_mismatch($sformatf("unexpected write response for id %0d", bid[i]));
               wr_pending[bid[i]]--;
               wr_done++;
            end
         end
      end
   end

   task automatic do_write(input int p, input axi_pkg::id_t id);
      logic [1:0] done;
      awid[p] = id;
      awaddr[p] = $random(seed);
      awaddr[p][2:0] = 3'b000;
      awlen[p] = 8'd0;
      awsize[p] = 3'd3;
      wdata[p] = {$random(seed), $random(seed)};
      wstrb[p] = $random(seed);
      wlast[p] = 1'b1;
      awvalid[p] = 1'b1;
      wvalid[p] = 1'b1;
      done = 2'b00;
      while (done != 2'b11) begin
         @(posedge clk);
         if (awvalid[p] && awready[p]) done[0] = 1'b1;
         if (wvalid[p] && wready[p]) done[1] = 1'b1;
         #2;
         if (done[0]) awvalid[p] = 1'b0;
         if (done[1]) wvalid[p] = 1'b0;
      end
   endtask

   task automatic do_read(input int p, input axi_pkg::id_t id);
      arid[p] = id;
      araddr[p] = $random(seed);
      araddr[p][2:0] = 3'b000;
      arlen[p] = 8'd0;
      arsize[p] = 3'd3;
      arvalid[p] = 1'b1;
      do @(posedge clk); while (!arready[p]);
      #2 arvalid[p] = 1'b0;
   endtask

   task automatic run_master(input int p);
      for (int i = 0; i < N_OPS; i++) begin
         do_write(p, p * 8 + i % 8);
         do_read(p, p * 8 + (i + 3) % 8);
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout: the transactions did not finish within %0d cycles", LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      seed = SEED;
      {clk, rstn, idle} = 3'b001;
      {awvalid, wvalid, arvalid, wlast} = '0;
      {awid, arid, awaddr, araddr, awlen, arlen, awsize, arsize, wdata, wstrb} = '0;
      rready = 2'b11;
      bready = 2'b11;
      repeat (16) @(posedge clk);
      #2 rstn = 1'b1;
      repeat (8) @(posedge clk);
      #2 idle = 1'b0;
      tests++;
      $display("test 1 idle after reset finished, errors %0d", errors);
      fork
         run_master(0);
         run_master(1);
      join
      while (wr_done + rd_done < 4 * N_OPS) @(posedge clk);
      repeat (4) @(posedge clk);
      tests++;
      $display("test 2 two masters with back-pressure finished, errors %0d", errors);
      assert (iss_aw == 2 * N_OPS && fwd_aw == iss_aw && fwd_w == iss_w && iss_w == iss_aw)
         else note_mismatch($sformatf("writes issued %0d, forwarded %0d", iss_aw, fwd_aw));
      assert (iss_ar == 2 * N_OPS && fwd_ar == iss_ar && rd_done == iss_ar)
         else note_mismatch($sformatf("reads issued %0d, forwarded %0d", iss_ar, fwd_ar));
      assert (wr_done == iss_aw)
         else note_mismatch($sformatf("writes %0d, responses %0d", iss_aw, wr_done));
      tests++;
      $display("test 3 transfer counts finished, errors %0d", errors);
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/axi_arbiter.sv
module axi_arbiter (
   input  logic           clk,
   input  logic           rstn,
   input  axi_pkg::id_t   a_awid,
   input  axi_pkg::addr_t a_awaddr,
   input  axi_pkg::len_t  a_awlen,
   input  axi_pkg::size_t a_awsize,
   input  logic           a_awvalid,
   output logic           a_awready,
   input  axi_pkg::data_t a_wdata,
   input  axi_pkg::strb_t a_wstrb,
   input  logic           a_wlast,
   input  logic           a_wvalid,
   output logic           a_wready,
   input  axi_pkg::id_t   a_arid,
   input  axi_pkg::addr_t a_araddr,
   input  axi_pkg::len_t  a_arlen,
   input  axi_pkg::size_t a_arsize,
   input  logic           a_arvalid,
   output logic           a_arready,
   output axi_pkg::id_t   a_rid,
   output axi_pkg::data_t a_rdata,
   output logic           a_rlast,
   output axi_pkg::resp_t a_rresp,
   output logic           a_rvalid,
   input  logic           a_rready,
   output axi_pkg::id_t   a_bid,
   output axi_pkg::resp_t a_bresp,
   output logic           a_bvalid,
   input  logic           a_bready,
   input  axi_pkg::id_t   b_awid,
   input  axi_pkg::addr_t b_awaddr,
   input  axi_pkg::len_t  b_awlen,
   input  axi_pkg::size_t b_awsize,
   input  logic           b_awvalid,
   output logic           b_awready,
   input  axi_pkg::data_t b_wdata,
   input  axi_pkg::strb_t b_wstrb,
   input  logic           b_wlast,
   input  logic           b_wvalid,
   output logic           b_wready,
   input  axi_pkg::id_t   b_arid,
   input  axi_pkg::addr_t b_araddr,
   input  axi_pkg::len_t  b_arlen,
   input  axi_pkg::size_t b_arsize,
   input  logic           b_arvalid,
   output logic           b_arready,
   output axi_pkg::id_t   b_rid,
   output axi_pkg::data_t b_rdata,
   output logic           b_rlast,
   output axi_pkg::resp_t b_rresp,
   output logic           b_rvalid,
   input  logic           b_rready,
   output axi_pkg::id_t   b_bid,
   output axi_pkg::resp_t b_bresp,
   output logic           b_bvalid,
   input  logic           b_bready,
   output axi_pkg::id_t   m_awid,
   output axi_pkg::addr_t m_awaddr,
   output axi_pkg::len_t  m_awlen,
   output axi_pkg::size_t m_awsize,
   output logic           m_awvalid,
   input  logic           m_awready,
   output axi_pkg::data_t m_wdata,
   output axi_pkg::strb_t m_wstrb,
   output logic           m_wlast,
   output logic           m_wvalid,
   input  logic           m_wready,
   output axi_pkg::id_t   m_arid,
   output axi_pkg::addr_t m_araddr,
   output axi_pkg::len_t  m_arlen,
   output axi_pkg::size_t m_arsize,
   output logic           m_arvalid,
   input  logic           m_arready,
   input  axi_pkg::id_t   m_rid,
   input  axi_pkg::data_t m_rdata,
   input  logic           m_rlast,
   input  axi_pkg::resp_t m_rresp,
   input  logic           m_rvalid,
   output logic           m_rready,
   input  axi_pkg::id_t   m_bid,
   input  axi_pkg::resp_t m_bresp,
   input  logic           m_bvalid,
   output logic           m_bready
);

   axi_pkg::id_t   s_awid, s_arid, s_rid, s_bid;  // arbiter side of the pipe
   axi_pkg::addr_t s_awaddr, s_araddr;
   axi_pkg::len_t  s_awlen, s_arlen;
   axi_pkg::size_t s_awsize, s_arsize;
   axi_pkg::data_t s_wdata, s_rdata;
   axi_pkg::strb_t s_wstrb;
   axi_pkg::resp_t s_rresp, s_bresp;
   logic           s_wlast, s_rlast;
   logic           s_awvalid, s_awready, s_wvalid, s_wready, s_arvalid, s_arready;
   logic           s_rvalid, s_rready, s_bvalid, s_bready;

   join_pkg::port_sel_t last_aw, last_ar;  // winner of the previous transfer
   join_pkg::port_sel_t aw_sel, ar_sel;
   join_pkg::port_sel_t w_owner;
   logic                w_waiting;  // an aw went through ahead of its w beat
   logic                aw_hs, ar_hs, w_hs;
   logic                w_go;

   assign aw_hs = s_awvalid & s_awready;
   assign ar_hs = s_arvalid & s_arready;
   assign w_hs = s_wvalid & s_wready;
   assign w_go = w_waiting | aw_hs;  // a w beat never overtakes its aw

   always_comb begin
      if (w_waiting) begin
         aw_sel = w_owner;
      end else if (last_aw == join_pkg::PORT_A) begin
         aw_sel = (a_awvalid || !b_awvalid) ? join_pkg::PORT_A : join_pkg::PORT_B;
      end else begin
         aw_sel = (b_awvalid || !a_awvalid) ? join_pkg::PORT_B : join_pkg::PORT_A;
      end

      if (last_ar == join_pkg::PORT_A) begin
         ar_sel = (a_arvalid || !b_arvalid) ? join_pkg::PORT_A : join_pkg::PORT_B;
      end else begin
         ar_sel = (b_arvalid || !a_arvalid) ? join_pkg::PORT_B : join_pkg::PORT_A;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_aw <= join_pkg::PORT_A;
         last_ar <= join_pkg::PORT_A;
         w_waiting <= 1'b0;
         w_owner <= join_pkg::PORT_A;
      end else begin
         if (aw_hs) last_aw <= aw_sel;
         if (ar_hs) last_ar <= ar_sel;
         if (aw_hs && !w_hs) begin
            w_waiting <= 1'b1;
            w_owner <= aw_sel;
         end else if (w_hs) begin
            w_waiting <= 1'b0;
         end
      end
   end

   always_comb begin
      if (aw_sel == join_pkg::PORT_B) begin
         {s_awid, s_awaddr, s_awlen, s_awsize} = {b_awid, b_awaddr, b_awlen, b_awsize};
         s_awvalid = b_awvalid & !w_waiting;
      end else begin
         {s_awid, s_awaddr, s_awlen, s_awsize} = {a_awid, a_awaddr, a_awlen, a_awsize};
         s_awvalid = a_awvalid & !w_waiting;
      end
   end

   always_comb begin
      if (aw_sel == join_pkg::PORT_B) begin
         {s_wdata, s_wstrb, s_wlast} = {b_wdata, b_wstrb, b_wlast};
         s_wvalid = b_wvalid & w_go;
      end else begin
         {s_wdata, s_wstrb, s_wlast} = {a_wdata, a_wstrb, a_wlast};
         s_wvalid = a_wvalid & w_go;
      end
   end

   always_comb begin
      if (ar_sel == join_pkg::PORT_B) begin
         {s_arid, s_araddr, s_arlen, s_arsize} = {b_arid, b_araddr, b_arlen, b_arsize};
         s_arvalid = b_arvalid;
      end else begin
         {s_arid, s_araddr, s_arlen, s_arsize} = {a_arid, a_araddr, a_arlen, a_arsize};
         s_arvalid = a_arvalid;
      end
   end

   assign a_awready = s_awready & (aw_sel == join_pkg::PORT_A) & !w_waiting;
   assign b_awready = s_awready & (aw_sel == join_pkg::PORT_B) & !w_waiting;
   assign a_wready = s_wready & (aw_sel == join_pkg::PORT_A) & w_go;
   assign b_wready = s_wready & (aw_sel == join_pkg::PORT_B) & w_go;
   assign a_arready = s_arready & (ar_sel == join_pkg::PORT_A);
   assign b_arready = s_arready & (ar_sel == join_pkg::PORT_B);

   // responses go to the master named by the id bit
   assign s_rready = s_rid[join_pkg::ID_BIT] ? b_rready : a_rready;
   assign s_bready = s_bid[join_pkg::ID_BIT] ? b_bready : a_bready;
   assign a_rvalid = s_rvalid & !s_rid[join_pkg::ID_BIT];
   assign b_rvalid = s_rvalid & s_rid[join_pkg::ID_BIT];
   assign a_bvalid = s_bvalid & !s_bid[join_pkg::ID_BIT];
   assign b_bvalid = s_bvalid & s_bid[join_pkg::ID_BIT];

   assign {a_rid, a_rdata, a_rlast, a_rresp} = {s_rid, s_rdata, s_rlast, s_rresp};
   assign {b_rid, b_rdata, b_rlast, b_rresp} = {s_rid, s_rdata, s_rlast, s_rresp};
   assign {a_bid, a_bresp} = {s_bid, s_bresp};
   assign {b_bid, b_bresp} = {s_bid, s_bresp};

   axi_pipe #(
      .STAGES(join_pkg::PIPE_STAGES),
      .NO_RESP(join_pkg::NO_RESP)
   ) axi_pipe_inst (.*);

   assert property (@(posedge clk) disable iff (!rstn) !(a_awready && b_awready));

   // the aw slice stays closed until the pending w beat has gone through
   assert property (@(posedge clk) disable iff (!rstn)
      w_waiting |-> !a_awready && !b_awready);

endmodule

//--- verilog/axi_join.sv
module axi_join (
   input  logic           clk,
   input  logic           rstn,
   input  axi_pkg::id_t   a_awid,
   input  axi_pkg::addr_t a_awaddr,
   input  axi_pkg::len_t  a_awlen,
   input  axi_pkg::size_t a_awsize,
   input  logic           a_awvalid,
   output logic           a_awready,
   input  axi_pkg::data_t a_wdata,
   input  axi_pkg::strb_t a_wstrb,
   input  logic           a_wlast,
   input  logic           a_wvalid,
   output logic           a_wready,
   input  axi_pkg::id_t   a_arid,
   input  axi_pkg::addr_t a_araddr,
   input  axi_pkg::len_t  a_arlen,
   input  axi_pkg::size_t a_arsize,
   input  logic           a_arvalid,
   output logic           a_arready,
   output axi_pkg::id_t   a_rid,
   output axi_pkg::data_t a_rdata,
   output logic           a_rlast,
   output axi_pkg::resp_t a_rresp,
   output logic           a_rvalid,
   input  logic           a_rready,
   output axi_pkg::id_t   a_bid,
   output axi_pkg::resp_t a_bresp,
   output logic           a_bvalid,
   input  logic           a_bready,
   input  axi_pkg::id_t   b_awid,
   input  axi_pkg::addr_t b_awaddr,
   input  axi_pkg::len_t  b_awlen,
   input  axi_pkg::size_t b_awsize,
   input  logic           b_awvalid,
   output logic           b_awready,
   input  axi_pkg::data_t b_wdata,
   input  axi_pkg::strb_t b_wstrb,
   input  logic           b_wlast,
   input  logic           b_wvalid,
   output logic           b_wready,
   input  axi_pkg::id_t   b_arid,
   input  axi_pkg::addr_t b_araddr,
   input  axi_pkg::len_t  b_arlen,
   input  axi_pkg::size_t b_arsize,
   input  logic           b_arvalid,
   output logic           b_arready,
   output axi_pkg::id_t   b_rid,
   output axi_pkg::data_t b_rdata,
   output logic           b_rlast,
   output axi_pkg::resp_t b_rresp,
   output logic           b_rvalid,
   input  logic           b_rready,
   output axi_pkg::id_t   b_bid,
   output axi_pkg::resp_t b_bresp,
   output logic           b_bvalid,
   input  logic           b_bready,
   output axi_pkg::id_t   m_awid,
   output axi_pkg::addr_t m_awaddr,
   output axi_pkg::len_t  m_awlen,
   output axi_pkg::size_t m_awsize,
   output logic           m_awvalid,
   input  logic           m_awready,
   output axi_pkg::data_t m_wdata,
   output axi_pkg::strb_t m_wstrb,
   output logic           m_wlast,
   output logic           m_wvalid,
   input  logic           m_wready,
   output axi_pkg::id_t   m_arid,
   output axi_pkg::addr_t m_araddr,
   output axi_pkg::len_t  m_arlen,
   output axi_pkg::size_t m_arsize,
   output logic           m_arvalid,
   input  logic           m_arready,
   input  axi_pkg::id_t   m_rid,
   input  axi_pkg::data_t m_rdata,
   input  logic           m_rlast,
   input  axi_pkg::resp_t m_rresp,
   input  logic           m_rvalid,
   output logic           m_rready,
   input  axi_pkg::id_t   m_bid,
   input  axi_pkg::resp_t m_bresp,
   input  logic           m_bvalid,
   output logic           m_bready
);

   // every port name matches the arbiter, so the ports connect by name
   axi_arbiter axi_arbiter_inst (.*);

endmodule

//--- verilog/axi_pipe.sv
module axi_pipe #(
   parameter int STAGES = join_pkg::PIPE_STAGES,
   parameter bit NO_RESP = join_pkg::NO_RESP
) (
   input  logic           clk,
   input  logic           rstn,
   input  axi_pkg::id_t   s_awid,
   input  axi_pkg::addr_t s_awaddr,
   input  axi_pkg::len_t  s_awlen,
   input  axi_pkg::size_t s_awsize,
   input  logic           s_awvalid,
   output logic           s_awready,
   input  axi_pkg::data_t s_wdata,
   input  axi_pkg::strb_t s_wstrb,
   input  logic           s_wlast,
   input  logic           s_wvalid,
   output logic           s_wready,
   input  axi_pkg::id_t   s_arid,
   input  axi_pkg::addr_t s_araddr,
   input  axi_pkg::len_t  s_arlen,
   input  axi_pkg::size_t s_arsize,
   input  logic           s_arvalid,
   output logic           s_arready,
   output axi_pkg::id_t   s_rid,
   output axi_pkg::data_t s_rdata,
   output logic           s_rlast,
   output axi_pkg::resp_t s_rresp,
   output logic           s_rvalid,
   input  logic           s_rready,
   output axi_pkg::id_t   s_bid,
   output axi_pkg::resp_t s_bresp,
   output logic           s_bvalid,
   input  logic           s_bready,
   output axi_pkg::id_t   m_awid,
   output axi_pkg::addr_t m_awaddr,
   output axi_pkg::len_t  m_awlen,
   output axi_pkg::size_t m_awsize,
   output logic           m_awvalid,
   input  logic           m_awready,
   output axi_pkg::data_t m_wdata,
   output axi_pkg::strb_t m_wstrb,
   output logic           m_wlast,
   output logic           m_wvalid,
   input  logic           m_wready,
   output axi_pkg::id_t   m_arid,
   output axi_pkg::addr_t m_araddr,
   output axi_pkg::len_t  m_arlen,
   output axi_pkg::size_t m_arsize,
   output logic           m_arvalid,
   input  logic           m_arready,
   input  axi_pkg::id_t   m_rid,
   input  axi_pkg::data_t m_rdata,
   input  logic           m_rlast,
   input  axi_pkg::resp_t m_rresp,
   input  logic           m_rvalid,
   output logic           m_rready,
   input  axi_pkg::id_t   m_bid,
   input  axi_pkg::resp_t m_bresp,
   input  logic           m_bvalid,
   output logic           m_bready
);

   localparam int RESP_STAGES = NO_RESP ? 0 : STAGES;  // responses may skip the registers

   register_slice #(.WIDTH(axi_pkg::AW_WIDTH), .STAGES(STAGES)) aw_slice (
      .clk(clk), .rstn(rstn),
      .s_valid(s_awvalid), .s_ready(s_awready),
      .s_data({s_awid, s_awaddr, s_awlen, s_awsize}),
      .m_valid(m_awvalid), .m_ready(m_awready),
      .m_data({m_awid, m_awaddr, m_awlen, m_awsize})
   );

   register_slice #(.WIDTH(axi_pkg::W_WIDTH), .STAGES(STAGES)) w_slice (
      .clk(clk), .rstn(rstn),
      .s_valid(s_wvalid), .s_ready(s_wready), .s_data({s_wdata, s_wstrb, s_wlast}),
      .m_valid(m_wvalid), .m_ready(m_wready), .m_data({m_wdata, m_wstrb, m_wlast})
   );

   register_slice #(.WIDTH(axi_pkg::AR_WIDTH), .STAGES(STAGES)) ar_slice (
      .clk(clk), .rstn(rstn),
      .s_valid(s_arvalid), .s_ready(s_arready),
      .s_data({s_arid, s_araddr, s_arlen, s_arsize}),
      .m_valid(m_arvalid), .m_ready(m_arready),
      .m_data({m_arid, m_araddr, m_arlen, m_arsize})
   );

   // the response slices run from the slave side back towards the arbiter
   register_slice #(.WIDTH(axi_pkg::R_WIDTH), .STAGES(RESP_STAGES)) r_slice (
      .clk(clk), .rstn(rstn),
      .s_valid(m_rvalid), .s_ready(m_rready), .s_data({m_rid, m_rdata, m_rlast, m_rresp}),
      .m_valid(s_rvalid), .m_ready(s_rready), .m_data({s_rid, s_rdata, s_rlast, s_rresp})
   );

   register_slice #(.WIDTH(axi_pkg::B_WIDTH), .STAGES(RESP_STAGES)) b_slice (
      .clk(clk), .rstn(rstn),
      .s_valid(m_bvalid), .s_ready(m_bready), .s_data({m_bid, m_bresp}),
      .m_valid(s_bvalid), .m_ready(s_bready), .m_data({s_bid, s_bresp})
   );

endmodule

//--- verilog/axi_pkg.sv
package axi_pkg;

   typedef logic [3:0]  id_t;    // transaction id
   typedef logic [31:0] addr_t;  // byte address
   typedef logic [7:0]  len_t;   // burst length field which is always 0 on the slave side
   typedef logic [2:0]  size_t;  // beat size code
   typedef logic [63:0] data_t;  // one data beat
   typedef logic [7:0]  strb_t;  // one strobe per data byte
   typedef logic [1:0]  resp_t;  // OKAY, EXOKAY, SLVERR, DECERR

   // packed payload of each channel without valid and ready
   localparam int AW_WIDTH = $bits(id_t) + $bits(addr_t) + $bits(len_t) + $bits(size_t);
   localparam int AR_WIDTH = $bits(id_t) + $bits(addr_t) + $bits(len_t) + $bits(size_t);
   localparam int W_WIDTH  = $bits(data_t) + $bits(strb_t) + 1;
   localparam int R_WIDTH  = $bits(id_t) + $bits(data_t) + 1 + $bits(resp_t);
   localparam int B_WIDTH  = $bits(id_t) + $bits(resp_t);

endpackage

//--- verilog/join_pkg.sv
package join_pkg;

   localparam int ID_BIT = 3;       // id bit that marks a master B transaction
   localparam int PIPE_STAGES = 1;  // register stages on every channel
   localparam bit NO_RESP = 1'b0;   // set to pass r and b straight through

   typedef enum logic {
      PORT_A,
      PORT_B
   } port_sel_t;

endpackage

//--- verilog/register_slice.sv
module register_slice #(
   parameter int WIDTH = 8,
   parameter int STAGES = 1
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             s_valid,
   output logic             s_ready,
   input  logic [WIDTH-1:0] s_data,
   output logic             m_valid,
   input  logic             m_ready,
   output logic [WIDTH-1:0] m_data
);

   generate
      if (STAGES == 0) begin : g_wire
         assign m_valid = s_valid;
         assign s_ready = m_ready;
         assign m_data = s_data;
      end else begin : g_chain
         logic [STAGES:0]  vld;
         logic [STAGES:0]  rdy;
         logic [WIDTH-1:0] dat [STAGES+1];

         assign vld[0] = s_valid;
         assign dat[0] = s_data;
         assign s_ready = rdy[0];
         assign m_valid = vld[STAGES];
         assign m_data = dat[STAGES];
         assign rdy[STAGES] = m_ready;

         for (genvar i = 0; i < STAGES; i++) begin : g_stage
            logic             main_valid;
            logic [WIDTH-1:0] main_data;
            logic             skid_valid;
            logic [WIDTH-1:0] skid_data;

            assign rdy[i] = !skid_valid;  // only the skid state decides ready
            assign vld[i+1] = main_valid;
            assign dat[i+1] = main_data;

            always_ff @(posedge clk) begin
               if (!rstn) begin
                  main_valid <= 1'b0;
                  skid_valid <= 1'b0;
               end else if (rdy[i+1] || !main_valid) begin
                  if (skid_valid) begin
                     main_valid <= 1'b1;  // drain the parked item first
                     skid_valid <= 1'b0;
                  end else begin
                     main_valid <= vld[i];
                  end
               end else if (vld[i] && !skid_valid) begin
                  skid_valid <= 1'b1;  // main is stalled so park the new item
               end
            end

            always_ff @(posedge clk) begin
               if (rdy[i+1] || !main_valid) begin
                  if (skid_valid) begin
                     main_data <= skid_data;
                  end else if (vld[i]) begin
                     main_data <= dat[i];
                  end
               end else if (vld[i] && !skid_valid) begin
                  skid_data <= dat[i];
               end
            end
         end
      end
   endgenerate

   // a stalled output has to hold its item across the whole chain
   assert property (@(posedge clk) disable iff (!rstn)
      m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule
